// ==== rs_settings.svh ====
/*
 * reservation station sizing
 * entry count, ROB tag space and datapath width
 * shared by the packages and the RTL
 */

`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// number of reservation station entries
// also the size of the dispatch credit pool
`define RS_DEPTH 8

// number of ROB tags
// power of two so tag arithmetic wraps by itself
`define ROB_DEPTH 16

// operand and result width
`define DATA_WIDTH 32

// shifts only look at this many low bits of operand b
`define SHAMT_WIDTH 5

`endif

// ==== alu_op_pkg.sv ====
/*
 * integer ALU types
 * opcode encoding and the data word carried on operands and CDB
 */

`default_nettype none

`include "rs_settings.svh"

package alu_op_pkg;

    // operand / result word
    typedef logic [`DATA_WIDTH-1:0] data_word_t;

    // 3-bit opcode, all eight codes used
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        // shift amount from low bits of b
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        // signed compare, result is 1 or 0
        ALU_SLT = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

// ==== rs_tag_pkg.sv ====
/*
 * reservation station tag types
 * ROB tag, entry index and the entry state encoding
 */

`default_nettype none

`include "rs_settings.svh"

package rs_tag_pkg;

    // tag of an in-flight instruction in the ROB
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

    // position of an entry inside the station
    typedef logic [$clog2(`RS_DEPTH)-1:0] rs_index_t;

    // entry life cycle
    // free -> wait -> ready -> free, or free -> ready straight away
    typedef enum logic [1:0] {
        ENTRY_FREE  = 2'd0,
        // at least one operand still pending
        ENTRY_WAIT  = 2'd1,
        // both operands captured, can issue
        ENTRY_READY = 2'd2
    } entry_state_e;

endpackage

`default_nettype wire

// ==== rs_entry.sv ====
/*
 * single reservation station entry
 * captures a dispatched instruction, snoops the CDB for its
 * pending operands and raises ready once both are present
 */

`default_nettype none

module rs_entry
    import rs_tag_pkg::*;
    import alu_op_pkg::*;
(
    input  wire logic    clock,
    input  wire logic    reset,
    input  wire logic    load,
    input  wire logic    clear,
    input  alu_op_e      load_op,
    input  rob_tag_t     load_tag,
    input  wire logic    load_src1_ready,
    input  rob_tag_t     load_src1_tag,
    input  data_word_t   load_src1_value,
    input  wire logic    load_src2_ready,
    input  rob_tag_t     load_src2_tag,
    input  data_word_t   load_src2_value,
    input  wire logic    cdb_valid,
    input  rob_tag_t     cdb_tag,
    input  data_word_t   cdb_value,
    output logic         busy,
    output logic         ready,
    output alu_op_e      entry_op,
    output rob_tag_t     entry_tag,
    output data_word_t   entry_a,
    output data_word_t   entry_b
);

    entry_state_e state;
    logic         src1_present;
    logic         src2_present;
    rob_tag_t     src1_tag;
    rob_tag_t     src2_tag;

    // bypass: producer broadcasting in the dispatch cycle
    logic load_hit1;
    logic load_hit2;
    // wakeup while parked in the station
    logic wake1;
    logic wake2;
    // operand presence after this edge
    logic src1_next;
    logic src2_next;

    assign load_hit1 = cdb_valid && !load_src1_ready && (cdb_tag == load_src1_tag);
    assign load_hit2 = cdb_valid && !load_src2_ready && (cdb_tag == load_src2_tag);

    assign wake1 = (state == ENTRY_WAIT) && cdb_valid && !src1_present && (cdb_tag == src1_tag);
    assign wake2 = (state == ENTRY_WAIT) && cdb_valid && !src2_present && (cdb_tag == src2_tag);

    assign src1_next = load ? (load_src1_ready || load_hit1) : (src1_present || wake1);
    assign src2_next = load ? (load_src2_ready || load_hit2) : (src2_present || wake2);

    assign busy  = (state != ENTRY_FREE);
    assign ready = (state == ENTRY_READY);

    //////////////////////////////////////////////////
    // state
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ENTRY_FREE;
        end else if (clear) begin
            // issued this cycle, slot goes back to the pool
            state <= ENTRY_FREE;
        end else if (load) begin
            state <= (src1_next && src2_next) ? ENTRY_READY : ENTRY_WAIT;
        end else if ((state == ENTRY_WAIT) && src1_next && src2_next) begin
            state <= ENTRY_READY;
        end
    end

    //////////////////////////////////////////////////
    // payload and operand capture
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        src1_present <= src1_next;
        src2_present <= src2_next;
        if (load) begin
            entry_op  <= load_op;
            entry_tag <= load_tag;
            src1_tag  <= load_src1_tag;
            src2_tag  <= load_src2_tag;
            entry_a   <= load_hit1 ? cdb_value : load_src1_value;
            entry_b   <= load_hit2 ? cdb_value : load_src2_value;
        end else begin
            // latch the broadcast value for a matching pending tag
            if (wake1) begin
                entry_a <= cdb_value;
            end
            if (wake2) begin
                entry_b <= cdb_value;
            end
        end
    end

    // allocation only ever picks a free slot
    a_load_free: assert property (@(posedge clock) disable iff (reset) load |-> !busy)
        else $error("rs_entry: load into a busy entry");

    // the selector only grants entries holding both operands
    a_clear_ready: assert property (@(posedge clock) disable iff (reset) clear |-> ready)
        else $error("rs_entry: clear of an entry that is not ready");

endmodule

`default_nettype wire

// ==== age_select.sv ====
/*
 * oldest-first issue selector
 * age of a requester is its ROB tag minus the ROB head mod ROB depth
 * a binary tree of two-way compare nodes keeps the smallest age,
 * so the oldest ready instruction wins and ties go to the lower index
 */

`default_nettype none

`include "rs_settings.svh"

module age_select
    import rs_tag_pkg::*;
(
    input  wire logic [`RS_DEPTH-1:0] request,
    input  rob_tag_t                  request_tag [`RS_DEPTH],
    input  rob_tag_t                  rob_head,
    output logic      [`RS_DEPTH-1:0] grant,
    output rs_index_t                 grant_index,
    output logic                      grant_valid
);

    // heap layout with node n over children 2n+1 and 2n+2
    // leaves sit at RS_DEPTH-1 .. 2*RS_DEPTH-2 in entry order
    localparam int NODES = 2 * `RS_DEPTH - 1;
    localparam int LEAF0 = `RS_DEPTH - 1;

    logic      node_valid [NODES];
    rob_tag_t  node_age   [NODES];
    rs_index_t node_index [NODES];
    logic      grant_oldest;

    //////////////////////////////////////////////////
    // leaves
    //////////////////////////////////////////////////

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_leaf
        assign node_valid[LEAF0 + i] = request[i];
        // tag width wraps the subtraction for us
        assign node_age[LEAF0 + i]   = request_tag[i] - rob_head;
        assign node_index[LEAF0 + i] = rs_index_t'(i);
    end

    //////////////////////////////////////////////////
    // compare tree
    //////////////////////////////////////////////////

    for (genvar n = 0; n < LEAF0; n++) begin : g_node
        logic take_left;

        // left wins if the right is idle or not older
        assign take_left = node_valid[2*n+1]
                        && (!node_valid[2*n+2] || (node_age[2*n+1] <= node_age[2*n+2]));

        assign node_valid[n] = node_valid[2*n+1] || node_valid[2*n+2];
        assign node_age[n]   = take_left ? node_age[2*n+1]   : node_age[2*n+2];
        assign node_index[n] = take_left ? node_index[2*n+1] : node_index[2*n+2];
    end

    // root carries the winner
    assign grant_valid = node_valid[0];
    assign grant_index = node_index[0];

    always_comb begin
        grant              = '0;
        grant[grant_index] = grant_valid;
    end

    // the winner is a requester and no requester is older than it
    always_comb begin
        grant_oldest = !grant_valid || request[grant_index];
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (grant_valid && request[i]
                && (rob_tag_t'(request_tag[i] - rob_head)
                    < rob_tag_t'(request_tag[grant_index] - rob_head))) begin
                grant_oldest = 1'b0;
            end
        end
        a_grant_oldest: assert (grant_oldest)
            else $error("age_select: grant is not the oldest request");
    end

endmodule

`default_nettype wire

// ==== reservation_station.sv ====
/*
 * reservation station
 * RS_DEPTH entries; dispatch fills the lowest free slot, the age
 * selector issues the oldest ready one, and each issue hands a
 * credit back to the dispatcher one cycle later
 */

`default_nettype none

`include "rs_settings.svh"

module reservation_station
    import rs_tag_pkg::*;
    import alu_op_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  rob_tag_t   rob_head,
    input  wire logic  dispatch_valid,
    input  alu_op_e    dispatch_op,
    input  rob_tag_t   dispatch_tag,
    input  wire logic  dispatch_src1_ready,
    input  rob_tag_t   dispatch_src1_tag,
    input  data_word_t dispatch_src1_value,
    input  wire logic  dispatch_src2_ready,
    input  rob_tag_t   dispatch_src2_tag,
    input  data_word_t dispatch_src2_value,
    input  wire logic  cdb_valid,
    input  rob_tag_t   cdb_tag,
    input  data_word_t cdb_value,
    output logic       credit_return,
    output logic       issue_valid,
    output alu_op_e    issue_op,
    output rob_tag_t   issue_tag,
    output data_word_t issue_a,
    output data_word_t issue_b
);

    logic [`RS_DEPTH-1:0] busy;
    logic [`RS_DEPTH-1:0] ready;
    logic [`RS_DEPTH-1:0] free;
    logic [`RS_DEPTH-1:0] free_lowest;
    logic [`RS_DEPTH-1:0] load;
    logic [`RS_DEPTH-1:0] grant;
    rs_index_t            grant_index;
    logic                 grant_valid;

    alu_op_e    entry_op  [`RS_DEPTH];
    rob_tag_t   entry_tag [`RS_DEPTH];
    data_word_t entry_a   [`RS_DEPTH];
    data_word_t entry_b   [`RS_DEPTH];

    //////////////////////////////////////////////////
    // allocation
    //////////////////////////////////////////////////

    // lowest set bit of the free mask
    assign free        = ~busy;
    assign free_lowest = free & (~free + 1'b1);
    assign load        = {`RS_DEPTH{dispatch_valid}} & free_lowest;

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_entry
        rs_entry u_entry (
            .clock           (clock),
            .reset           (reset),
            .load            (load[i]),
            // the issued entry frees at the next edge
            .clear           (grant[i]),
            .load_op         (dispatch_op),
            .load_tag        (dispatch_tag),
            .load_src1_ready (dispatch_src1_ready),
            .load_src1_tag   (dispatch_src1_tag),
            .load_src1_value (dispatch_src1_value),
            .load_src2_ready (dispatch_src2_ready),
            .load_src2_tag   (dispatch_src2_tag),
            .load_src2_value (dispatch_src2_value),
            .cdb_valid       (cdb_valid),
            .cdb_tag         (cdb_tag),
            .cdb_value       (cdb_value),
            .busy            (busy[i]),
            .ready           (ready[i]),
            .entry_op        (entry_op[i]),
            .entry_tag       (entry_tag[i]),
            .entry_a         (entry_a[i]),
            .entry_b         (entry_b[i])
        );
    end

    //////////////////////////////////////////////////
    // issue select and mux
    //////////////////////////////////////////////////

    age_select u_select (
        .request     (ready),
        .request_tag (entry_tag),
        .rob_head    (rob_head),
        .grant       (grant),
        .grant_index (grant_index),
        .grant_valid (grant_valid)
    );

    // combinational from entry state, no back-pressure from the ALU
    assign issue_valid = grant_valid;
    assign issue_op    = entry_op[grant_index];
    assign issue_tag   = entry_tag[grant_index];
    assign issue_a     = entry_a[grant_index];
    assign issue_b     = entry_b[grant_index];

    // one credit back per issue, a cycle later
    always_ff @(posedge clock) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= grant_valid;
        end
    end

    // a credit always means a free slot, otherwise the dispatcher overspent
    a_credit_ok: assert property (@(posedge clock) disable iff (reset)
        dispatch_valid |-> !(&busy))
        else $error("reservation_station: dispatch with every entry busy");

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
/*
 * two-stage integer ALU
 * stage 1 registers the issued operands, stage 2 computes and
 * registers the result onto the CDB; one op per cycle
 */

`default_nettype none

`include "rs_settings.svh"

module alu_unit
    import rs_tag_pkg::*;
    import alu_op_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  issue_valid,
    input  alu_op_e    issue_op,
    input  rob_tag_t   issue_tag,
    input  data_word_t issue_a,
    input  data_word_t issue_b,
    output logic       cdb_valid,
    output rob_tag_t   cdb_tag,
    output data_word_t cdb_value
);

    logic       s1_valid;
    alu_op_e    s1_op;
    rob_tag_t   s1_tag;
    data_word_t s1_a;
    data_word_t s1_b;
    data_word_t result;

    //////////////////////////////////////////////////
    // stage 1: operand capture
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
        s1_op  <= issue_op;
        s1_tag <= issue_tag;
        s1_a   <= issue_a;
        s1_b   <= issue_b;
    end

    // function of the op
    always_comb begin
        unique case (s1_op)
            ALU_ADD: result = s1_a + s1_b;
            ALU_SUB: result = s1_a - s1_b;
            ALU_AND: result = s1_a & s1_b;
            ALU_OR:  result = s1_a | s1_b;
            ALU_XOR: result = s1_a ^ s1_b;
            ALU_SLL: result = s1_a << s1_b[`SHAMT_WIDTH-1:0];
            ALU_SRL: result = s1_a >> s1_b[`SHAMT_WIDTH-1:0];
            ALU_SLT: result = data_word_t'($signed(s1_a) < $signed(s1_b));
            default: result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // stage 2: CDB drive
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= s1_valid;
        end
        cdb_tag   <= s1_tag;
        cdb_value <= result;
    end

endmodule

`default_nettype wire

// ==== rs_core.sv ====
/*
 * issue subsystem top
 * reservation station feeding one integer ALU, with the ALU's
 * CDB looped back for wakeup and driven out as the result
 */

`default_nettype none

module rs_core
    import rs_tag_pkg::*;
    import alu_op_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  rob_tag_t   rob_head,
    input  wire logic  dispatch_valid,
    input  alu_op_e    dispatch_op,
    input  rob_tag_t   dispatch_tag,
    input  wire logic  dispatch_src1_ready,
    input  rob_tag_t   dispatch_src1_tag,
    input  data_word_t dispatch_src1_value,
    input  wire logic  dispatch_src2_ready,
    input  rob_tag_t   dispatch_src2_tag,
    input  data_word_t dispatch_src2_value,
    output logic       credit_return,
    output logic       cdb_valid,
    output rob_tag_t   cdb_tag,
    output data_word_t cdb_value
);

    // station to ALU, no flow control
    logic       issue_valid;
    alu_op_e    issue_op;
    rob_tag_t   issue_tag;
    data_word_t issue_a;
    data_word_t issue_b;

    reservation_station u_station (
        .clock               (clock),
        .reset               (reset),
        .rob_head            (rob_head),
        .dispatch_valid      (dispatch_valid),
        .dispatch_op         (dispatch_op),
        .dispatch_tag        (dispatch_tag),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src1_tag   (dispatch_src1_tag),
        .dispatch_src1_value (dispatch_src1_value),
        .dispatch_src2_ready (dispatch_src2_ready),
        .dispatch_src2_tag   (dispatch_src2_tag),
        .dispatch_src2_value (dispatch_src2_value),
        // wakeup straight from the ALU's result register
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .cdb_value           (cdb_value),
        .credit_return       (credit_return),
        .issue_valid         (issue_valid),
        .issue_op            (issue_op),
        .issue_tag           (issue_tag),
        .issue_a             (issue_a),
        .issue_b             (issue_b)
    );

    alu_unit u_alu (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_tag   (issue_tag),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

endmodule

`default_nettype wire

// ==== rs_core_tb.sv ====
/*
 * rs_core testbench
 * stands in for the ROB and map table by allocating tags and tracking credits,
 * models every result and checks the CDB with concurrent assertions
 */

`default_nettype none

`include "rs_settings.svh"

module rs_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rs_tag_pkg::*;
    import alu_op_pkg::*;

    localparam int RANDOM_CYCLES   = 600;
    localparam int TEST_CYCLES     = RANDOM_CYCLES + 8 * 20 + 4 * `RS_DEPTH;
    localparam int MAX_OUTSTANDING = `ROB_DEPTH - 2;
    localparam int KIND_READY      = 0;
    localparam int KIND_CHAIN      = 1;
    localparam int KIND_RANDOM     = 2;

    logic       clock;
    logic       reset;
    rob_tag_t   rob_head;
    logic       dispatch_valid;
    alu_op_e    dispatch_op;
    rob_tag_t   dispatch_tag;
    logic       dispatch_src1_ready;
    rob_tag_t   dispatch_src1_tag;
    data_word_t dispatch_src1_value;
    logic       dispatch_src2_ready;
    rob_tag_t   dispatch_src2_tag;
    data_word_t dispatch_src2_value;
    logic       credit_return;
    logic       cdb_valid;
    rob_tag_t   cdb_tag;
    data_word_t cdb_value;

    // model of the ROB side
    logic [15:0] lfsr_state;
    data_word_t  expected [`ROB_DEPTH];
    int          dispatch_count [`ROB_DEPTH];
    int          bcast_count [`ROB_DEPTH];
    int          credits;
    int          alloc_count;
    int          head_count;
    logic        lat_probe;
    rob_tag_t    chain_tag;
    logic        older_ready;
    rob_tag_t    issue_age;

    rs_core u_dut (.*);

    always #4 clock = ~clock;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // galois LFSR stepped once per bit
    function automatic logic take_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 16'hB400 : 16'h0000);
        return b;
    endfunction

    function automatic data_word_t take_bits(input int n);
        data_word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[`DATA_WIDTH-2:0], take_bit()};
        end
        return v;
    endfunction

    // reference ALU from the opcode rules
    function automatic data_word_t alu_model(input alu_op_e op, input data_word_t a,
                                             input data_word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // dispatched, not broadcast, and not on the CDB this edge
    function automatic bit is_pending(input rob_tag_t t);
        return (dispatch_count[t] != bcast_count[t]) && !(cdb_valid && (cdb_tag == t));
    endfunction

    task automatic pick_source(input bit use_tag, input rob_tag_t want_tag, output logic rdy,
                               output rob_tag_t tag, output data_word_t drive_val,
                               output data_word_t model_val);
        tag = want_tag;
        if (use_tag && is_pending(want_tag)) begin
            // value port is junk while waiting
            rdy       = 1'b0;
            drive_val = take_bits(32);
            model_val = expected[want_tag];
        end else if (use_tag) begin
            rdy       = 1'b1;
            drive_val = expected[want_tag];
            model_val = drive_val;
        end else begin
            rdy       = 1'b1;
            tag       = rob_tag_t'(take_bits(4));
            drive_val = take_bits(32);
            model_val = drive_val;
        end
    endtask

    ////////////////////////////////////////////////////
    // one clock of dispatch and head bookkeeping
    ////////////////////////////////////////////////////

    task automatic step(input bit want, input int kind);
        int         avail;
        int         outstanding;
        bit         p1;
        bit         p2;
        rob_tag_t   w1;
        rob_tag_t   w2;
        logic       r1;
        logic       r2;
        rob_tag_t   t1;
        rob_tag_t   t2;
        data_word_t d1;
        data_word_t d2;
        data_word_t m1;
        data_word_t m2;
        data_word_t opbits;
        alu_op_e    op;
        rob_tag_t   new_tag;
        @(posedge clock);
        // retire done tags in order
        while (head_count < alloc_count
               && !is_pending(rob_tag_t'(head_count % `ROB_DEPTH))) begin
            head_count++;
        end
        rob_head <= rob_tag_t'(head_count % `ROB_DEPTH);
        avail = credits - int'(dispatch_valid) + int'(credit_return);
        outstanding = alloc_count - head_count;
        lat_probe <= 1'b0;
        if (want && avail > 0 && outstanding < MAX_OUTSTANDING) begin
            opbits = take_bits(3);
            op = alu_op_e'(opbits[2:0]);
            p1 = 1'b0;
            p2 = 1'b0;
            w1 = '0;
            w2 = '0;
            if (kind == KIND_CHAIN) begin
                p1 = 1'b1;
                w1 = chain_tag;
            end else if (kind == KIND_RANDOM && outstanding > 0) begin
                p1 = take_bit();
                w1 = rob_tag_t'((head_count + int'(take_bits(4)) % outstanding) % `ROB_DEPTH);
                p2 = take_bit();
                w2 = rob_tag_t'((head_count + int'(take_bits(4)) % outstanding) % `ROB_DEPTH);
            end
            pick_source(p1, w1, r1, t1, d1, m1);
            pick_source(p2, w2, r2, t2, d2, m2);
            new_tag = rob_tag_t'(alloc_count % `ROB_DEPTH);
            dispatch_valid      <= 1'b1;
            dispatch_op         <= op;
            dispatch_tag        <= new_tag;
            dispatch_src1_ready <= r1;
            dispatch_src1_tag   <= t1;
            dispatch_src1_value <= d1;
            dispatch_src2_ready <= r2;
            dispatch_src2_tag   <= t2;
            dispatch_src2_value <= d2;
            expected[new_tag]       <= alu_model(op, m1, m2);
            dispatch_count[new_tag] <= dispatch_count[new_tag] + 1;
            // empty station, so the fixed latency applies
            lat_probe <= (kind == KIND_READY) && (avail == `RS_DEPTH);
            alloc_count++;
        end else begin
            dispatch_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        do begin
            step(1'b0, KIND_READY);
        end while (head_count != alloc_count);
        repeat (3) step(1'b0, KIND_READY);
    endtask

    // credit pool and broadcast count
    always @(posedge clock) begin
        if (reset) begin
            credits <= `RS_DEPTH;
        end else begin
            credits <= credits - int'(dispatch_valid) + int'(credit_return);
            if (cdb_valid) begin
                bcast_count[cdb_tag] <= bcast_count[cdb_tag] + 1;
            end
        end
    end

    // any ready entry older than the one issuing
    always_comb begin
        older_ready = 1'b0;
        issue_age = u_dut.u_station.issue_tag - rob_head;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (u_dut.u_station.ready[i]
                && rob_tag_t'(u_dut.u_station.entry_tag[i] - rob_head) < issue_age) begin
                older_ready = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////

    a_value: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> (cdb_value == expected[cdb_tag]))
        else abort_run($sformatf("Error result_value tag %0d expected %h actual %h",
                                 cdb_tag, expected[cdb_tag], cdb_value));

    a_once: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> (dispatch_count[cdb_tag] != bcast_count[cdb_tag]))
        else abort_run($sformatf("broadcast of tag %0d that is not in flight", cdb_tag));

    a_credit: assert property (@(posedge clock) disable iff (reset)
        (credits <= `RS_DEPTH) && (!dispatch_valid || credits > 0))
        else abort_run($sformatf("Error credit_bound expected <= %0d actual %0d",
                                 `RS_DEPTH, credits));

    a_latency: assert property (@(posedge clock) disable iff (reset)
        lat_probe |-> ##3 (cdb_valid && cdb_tag == $past(dispatch_tag, 3)))
        else abort_run("result did not broadcast 3 cycles after dispatch");

    a_age: assert property (@(posedge clock) disable iff (reset)
        u_dut.u_station.issue_valid |-> !older_ready)
        else abort_run("an instruction issued ahead of an older ready one");

    a_reset: assert property (@(posedge clock) $past(reset) |-> (!credit_return && !cdb_valid))
        else abort_run("credit_return or cdb_valid high during reset");

    // watchdog
    initial begin
        repeat (TEST_CYCLES * `RS_DEPTH * 4) @(posedge clock);
        abort_run("timeout, results never drained");
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        lfsr_state = 16'd35948;
        rob_head = '0;
        dispatch_valid = 1'b0;
        dispatch_op = ALU_ADD;
        dispatch_tag = '0;
        dispatch_src1_ready = 1'b0;
        dispatch_src1_tag = '0;
        dispatch_src1_value = '0;
        dispatch_src2_ready = 1'b0;
        dispatch_src2_tag = '0;
        dispatch_src2_value = '0;
        credits = `RS_DEPTH;
        alloc_count = 0;
        head_count = 0;
        lat_probe = 1'b0;
        chain_tag = '0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            expected[i] = '0;
            dispatch_count[i] = 0;
            bcast_count[i] = 0;
        end
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        // latency probes into an idle station
        repeat (8) begin
            step(1'b1, KIND_READY);
            drain();
        end

        // producer then a full burst waiting on it
        repeat (2) begin
            step(1'b1, KIND_READY);
            chain_tag = rob_tag_t'((alloc_count - 1) % `ROB_DEPTH);
            for (int i = 0; i < `RS_DEPTH - 1; i++) begin
                step(1'b1, KIND_CHAIN);
            end
            drain();
        end

        // random mix with idle cycles
        repeat (RANDOM_CYCLES) begin
            step(take_bits(2) != 0, KIND_RANDOM);
        end
        drain();

        if (credits != `RS_DEPTH) begin
            abort_run($sformatf("Error credit_final expected %0d actual %0d",
                                `RS_DEPTH, credits));
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rs_core.f ====
+incdir+.
alu_op_pkg.sv
rs_tag_pkg.sv
rs_entry.sv
age_select.sv
reservation_station.sv
alu_unit.sv
rs_core.sv
rs_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the rs_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f rs_core.f \
    --top-module rs_core_tb \
    -o rs_core_sim

# a failing run stops with a nonzero status, keep going so the search decides
sim_output=$(./obj_dir/rs_core_sim 2>&1) || true
echo "$sim_output"

if grep -q "Finished with no errors" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi
